// File: Makefile
SOURCES := $(shell grep -v '^+' ooo_core.f) sim/tb_ooo_model.svh

.PHONY: all run clean

all: run

obj_dir/Vtb_ooo_core: ooo_core.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f ooo_core.f \
		--top-module tb_ooo_core -o Vtb_ooo_core

run: obj_dir/Vtb_ooo_core
	./obj_dir/Vtb_ooo_core 2>&1 | tee sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" sim.log; then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: logic/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
  input  logic clk_100mhz,
  input  logic sys_rst,
  input  logic i_valid,
  input  ooo_pkg::rs_entry_t i_entry,
  input  logic i_taken,
  output logic o_busy,
  output ooo_pkg::fu_result_t o_result
);
  import ooo_pkg::*;

  word_t a;
  word_t b;
  word_t y;
  fu_result_t res_q;

  assign a = i_entry.src1.value;
  assign b = i_entry.src2.value;

  always_comb begin
    case (i_entry.op)
      ADD:  y = a + b;
      SUB:  y = a - b;
      AND:  y = a & b;
      OR:   y = a | b;
      XOR:  y = a ^ b;
      SLL:  y = a << b[4:0];
      SRL:  y = a >> b[4:0];
      SRA:  y = $signed(a) >>> b[4:0];
      SLT:  y = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      SLTU: y = {{(XLEN-1){1'b0}}, a < b};
      default: y = '0; // MUL never lands here
    endcase
  end

  // free again in the cycle the arbiter takes the result
  assign o_busy = res_q.valid && !i_taken;
  assign o_result = res_q;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      res_q.valid <= 1'b0;
    end else if (i_valid) begin
      res_q.valid <= 1'b1;
      res_q.tag <= i_entry.dest;
      res_q.value <= y;
    end else if (i_taken) begin
      res_q.valid <= 1'b0;
    end
  end

endmodule

// File: logic/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter (
  input  logic clk_100mhz,
  input  logic sys_rst,
  input  ooo_pkg::fu_result_t i_alu,
  input  ooo_pkg::fu_result_t i_mul,
  output logic o_alu_taken,
  output logic o_mul_taken,
  output ooo_pkg::cdb_t o_cdb
);
  import ooo_pkg::*;

  cdb_t cdb_q;

  assign o_alu_taken = i_alu.valid; // ALU always wins
  assign o_mul_taken = i_mul.valid && !i_alu.valid;
  assign o_cdb = cdb_q;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      cdb_q.valid <= 1'b0;
    end else begin
      cdb_q.valid <= o_alu_taken || o_mul_taken;
      cdb_q.tag <= o_alu_taken ? i_alu.tag : i_mul.tag;
      cdb_q.value <= o_alu_taken ? i_alu.value : i_mul.value;
    end
  end

  // a granted result leaves its unit, so it is never broadcast twice
  a_alu_released: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    o_alu_taken |=> !(i_alu.valid && i_alu.tag == $past(i_alu.tag)));

  a_mul_released: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    o_mul_taken |=> !(i_mul.valid && i_mul.tag == $past(i_mul.tag)));

endmodule

// File: logic/issue_unit.sv
`timescale 1ns/1ps

module issue_unit #(
  parameter int RS_DEPTH = 4
) (
  input  logic i_op_valid,
  input  ooo_pkg::uop_t i_op,
  input  logic [$clog2(RS_DEPTH+1)-1:0] i_rs_alu_free, // free slot counts
  input  logic [$clog2(RS_DEPTH+1)-1:0] i_rs_mul_free,
  input  logic i_rob_full,
  input  ooo_pkg::rob_tag_t i_alloc_tag,
  input  logic [1:0] i_src_tag_pending,
  input  ooo_pkg::rob_tag_t [1:0] i_src_tag,
  input  ooo_pkg::word_t [1:0] i_rf_value,
  input  logic [1:0] i_rob_done,
  input  ooo_pkg::word_t [1:0] i_rob_value,
  output logic o_op_ready,
  output logic o_alloc,
  output logic o_rs_alu_insert,
  output logic o_rs_mul_insert,
  output ooo_pkg::rs_entry_t o_entry,
  output ooo_pkg::reg_idx_t [1:0] o_src_idx
);
  import ooo_pkg::*;

  logic is_mul;
  logic station_free;
  operand_t [1:0] src;

  assign is_mul = (i_op.op == MUL);
  assign station_free = is_mul ? (i_rs_mul_free != '0) : (i_rs_alu_free != '0);
  assign o_op_ready = !i_rob_full && station_free;
  assign o_alloc = i_op_valid && o_op_ready;
  assign o_rs_alu_insert = o_alloc && !is_mul;
  assign o_rs_mul_insert = o_alloc && is_mul;

  assign o_src_idx[0] = i_op.rs1;
  assign o_src_idx[1] = i_op.rs2;

  always_comb begin
    for (int k = 0; k < 2; k++) begin
      src[k].tag = i_src_tag[k];
      if (o_src_idx[k] == '0) begin // x0
        src[k].ready = 1'b1;
        src[k].value = '0;
      end else if (!i_src_tag_pending[k]) begin
        src[k].ready = 1'b1;
        src[k].value = i_rf_value[k];
      end else begin
        // producer may already have finished but not committed
        src[k].ready = i_rob_done[k];
        src[k].value = i_rob_value[k];
      end
    end
    if (i_op.use_imm) begin
      src[1].ready = 1'b1;
      src[1].value = {{(XLEN-IMM_W){i_op.imm[IMM_W-1]}}, i_op.imm};
    end
  end

  assign o_entry = '{op: i_op.op, src1: src[0], src2: src[1], dest: i_alloc_tag};

endmodule

// File: logic/mul_unit.sv
`timescale 1ns/1ps

module mul_unit (
  input  logic clk_100mhz,
  input  logic sys_rst,
  input  logic i_valid,
  input  ooo_pkg::rs_entry_t i_entry,
  input  logic i_taken,
  output logic o_busy,
  output ooo_pkg::fu_result_t o_result
);
  import ooo_pkg::*;

  typedef struct packed {
    logic valid;
    rob_tag_t tag;
    word_t part_lo; // a * b[15:0]
    word_t part_hi; // a * b[31:16]
  } mul_part_t;

  word_t a;
  word_t b;
  mul_part_t s1;
  fu_result_t s2;
  fu_result_t s3; // output stage
  logic advance;

  assign a = i_entry.src1.value;
  assign b = i_entry.src2.value;

  assign advance = !s3.valid || i_taken;
  assign o_busy = !advance;
  assign o_result = s3;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      s1.valid <= 1'b0;
      s2.valid <= 1'b0;
      s3.valid <= 1'b0;
    end else if (advance) begin
      s1.valid <= i_valid;
      s1.tag <= i_entry.dest;
      s1.part_lo <= a * {16'h0, b[15:0]};
      s1.part_hi <= a * {16'h0, b[31:16]};
      s2.valid <= s1.valid;
      s2.tag <= s1.tag;
      s2.value <= s1.part_lo + {s1.part_hi[15:0], 16'h0}; // low 32 bits only
      s3 <= s2;
    end
  end

endmodule

// File: logic/ooo_core.sv
`timescale 1ns/1ps

module ooo_core #(
  parameter int RS_DEPTH = 4
) (
  input  logic clk_100mhz,
  input  logic sys_rst,
  input  logic i_op_valid,
  input  ooo_pkg::uop_t i_op,
  output logic o_op_ready,
  output logic o_commit_valid,
  output ooo_pkg::reg_idx_t o_commit_rd,
  output ooo_pkg::word_t o_commit_value
);
  import ooo_pkg::*;

  localparam int FREE_W = $clog2(RS_DEPTH + 1);

  // issue and rename
  logic alloc;
  logic rs_alu_insert;
  logic rs_mul_insert;
  logic rob_full;
  logic [FREE_W-1:0] rs_alu_free;
  logic [FREE_W-1:0] rs_mul_free;
  rs_entry_t issue_entry;
  reg_idx_t [1:0] src_idx;
  logic [1:0] src_pending;
  rob_tag_t [1:0] src_tag;
  word_t [1:0] rf_value;
  logic [1:0] lookup_done;
  word_t [1:0] lookup_value;
  rob_tag_t alloc_tag;
  rob_tag_t commit_tag;

  // execute and writeback
  logic alu_issue_valid;
  logic mul_issue_valid;
  rs_entry_t alu_issue;
  rs_entry_t mul_issue;
  logic alu_busy;
  logic mul_busy;
  logic alu_taken;
  logic mul_taken;
  fu_result_t alu_result;
  fu_result_t mul_result;
  cdb_t cdb;

  issue_unit #(.RS_DEPTH(RS_DEPTH)) u_issue (
    .i_op_valid(i_op_valid),
    .i_op(i_op),
    .i_rs_alu_free(rs_alu_free),
    .i_rs_mul_free(rs_mul_free),
    .i_rob_full(rob_full || sys_rst), // no issue while in reset
    .i_alloc_tag(alloc_tag),
    .i_src_tag_pending(src_pending),
    .i_src_tag(src_tag),
    .i_rf_value(rf_value),
    .i_rob_done(lookup_done),
    .i_rob_value(lookup_value),
    .o_op_ready(o_op_ready),
    .o_alloc(alloc),
    .o_rs_alu_insert(rs_alu_insert),
    .o_rs_mul_insert(rs_mul_insert),
    .o_entry(issue_entry),
    .o_src_idx(src_idx)
  );

  register_status u_regs (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .i_src_idx(src_idx),
    .i_alloc(alloc),
    .i_alloc_rd(i_op.rd),
    .i_alloc_tag(alloc_tag),
    .i_commit_valid(o_commit_valid),
    .i_commit_rd(o_commit_rd),
    .i_commit_tag(commit_tag),
    .i_commit_value(o_commit_value),
    .o_tag_pending(src_pending),
    .o_tag(src_tag),
    .o_value(rf_value)
  );

  reorder_buffer u_rob (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .i_alloc(alloc),
    .i_alloc_rd(i_op.rd),
    .i_cdb(cdb),
    .i_lookup_tag(src_tag),
    .o_alloc_tag(alloc_tag),
    .o_full(rob_full),
    .o_lookup_done(lookup_done),
    .o_lookup_value(lookup_value),
    .o_commit_valid(o_commit_valid),
    .o_commit_rd(o_commit_rd),
    .o_commit_tag(commit_tag),
    .o_commit_value(o_commit_value)
  );

  reservation_station #(.RS_DEPTH(RS_DEPTH)) rs_alu (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .i_insert(rs_alu_insert),
    .i_entry(issue_entry),
    .i_cdb(cdb),
    .i_fu_busy(alu_busy),
    .o_free(rs_alu_free),
    .o_issue_valid(alu_issue_valid),
    .o_issue(alu_issue)
  );

  reservation_station #(.RS_DEPTH(RS_DEPTH)) rs_mul (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .i_insert(rs_mul_insert),
    .i_entry(issue_entry),
    .i_cdb(cdb),
    .i_fu_busy(mul_busy),
    .o_free(rs_mul_free),
    .o_issue_valid(mul_issue_valid),
    .o_issue(mul_issue)
  );

  alu_unit u_alu (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .i_valid(alu_issue_valid),
    .i_entry(alu_issue),
    .i_taken(alu_taken),
    .o_busy(alu_busy),
    .o_result(alu_result)
  );

  mul_unit u_mul (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .i_valid(mul_issue_valid),
    .i_entry(mul_issue),
    .i_taken(mul_taken),
    .o_busy(mul_busy),
    .o_result(mul_result)
  );

  cdb_arbiter u_cdb (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .i_alu(alu_result),
    .i_mul(mul_result),
    .o_alu_taken(alu_taken),
    .o_mul_taken(mul_taken),
    .o_cdb(cdb)
  );

endmodule

// File: logic/ooo_pkg.sv
package ooo_pkg;

  localparam int XLEN = 32;
  localparam int NUM_REGS = 32; // x0 reads as zero
  localparam int ROB_DEPTH = 8;
  localparam int IMM_W = 28;
  localparam int REG_IDX_W = $clog2(NUM_REGS);
  localparam int ROB_TAG_W = $clog2(ROB_DEPTH);

  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [ROB_TAG_W-1:0] rob_tag_t;
  typedef logic [XLEN-1:0] word_t;

  // MUL goes to the multiply station, everything else to the ALU
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    SLT  = 4'd8,
    SLTU = 4'd9,
    MUL  = 4'd10
  } alu_op_e;

  typedef struct packed {
    alu_op_e op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic use_imm;
    logic [IMM_W-1:0] imm; // sign-extended at issue
  } uop_t;

  typedef struct packed {
    logic ready;
    rob_tag_t tag;   // producer, meaningful while not ready
    word_t value;
  } operand_t;

  typedef struct packed {
    alu_op_e op;
    operand_t src1;
    operand_t src2;
    rob_tag_t dest;
  } rs_entry_t;

  typedef struct packed {
    logic valid;
    rob_tag_t tag;
    word_t value;
  } cdb_t;

  typedef struct packed {
    logic valid;
    rob_tag_t tag;
    word_t value;
  } fu_result_t;

endpackage

// File: logic/register_status.sv
`timescale 1ns/1ps

module register_status (
  input  logic clk_100mhz,
  input  logic sys_rst,
  input  ooo_pkg::reg_idx_t [1:0] i_src_idx,
  input  logic i_alloc,
  input  ooo_pkg::reg_idx_t i_alloc_rd,
  input  ooo_pkg::rob_tag_t i_alloc_tag,
  input  logic i_commit_valid,
  input  ooo_pkg::reg_idx_t i_commit_rd,
  input  ooo_pkg::rob_tag_t i_commit_tag,
  input  ooo_pkg::word_t i_commit_value,
  output logic [1:0] o_tag_pending,
  output ooo_pkg::rob_tag_t [1:0] o_tag,
  output ooo_pkg::word_t [1:0] o_value
);
  import ooo_pkg::*;

  logic [NUM_REGS-1:0] pending; // rename tag valid
  rob_tag_t tags [NUM_REGS];
  word_t rf [NUM_REGS];

  always_comb begin
    for (int k = 0; k < 2; k++) begin
      o_tag_pending[k] = pending[i_src_idx[k]];
      o_tag[k] = tags[i_src_idx[k]];
      o_value[k] = (i_src_idx[k] == '0) ? '0 : rf[i_src_idx[k]];
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      pending <= '0;
      for (int r = 0; r < NUM_REGS; r++) begin
        rf[r] <= '0;
      end
    end else begin
      if (i_commit_valid && i_commit_rd != '0) begin
        rf[i_commit_rd] <= i_commit_value;
        // only the newest writer clears the tag
        if (tags[i_commit_rd] == i_commit_tag) begin
          pending[i_commit_rd] <= 1'b0;
        end
      end
      // a fresh rename beats the commit clear above
      if (i_alloc && i_alloc_rd != '0) begin
        pending[i_alloc_rd] <= 1'b1;
        tags[i_alloc_rd] <= i_alloc_tag;
      end
    end
  end

endmodule

// File: logic/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer (
  input  logic clk_100mhz,
  input  logic sys_rst,
  input  logic i_alloc,
  input  ooo_pkg::reg_idx_t i_alloc_rd,
  input  ooo_pkg::cdb_t i_cdb,
  input  ooo_pkg::rob_tag_t [1:0] i_lookup_tag,
  output ooo_pkg::rob_tag_t o_alloc_tag,
  output logic o_full,
  output logic [1:0] o_lookup_done,
  output ooo_pkg::word_t [1:0] o_lookup_value,
  output logic o_commit_valid,
  output ooo_pkg::reg_idx_t o_commit_rd,
  output ooo_pkg::rob_tag_t o_commit_tag,
  output ooo_pkg::word_t o_commit_value
);
  import ooo_pkg::*;

  logic [ROB_DEPTH-1:0] live;
  logic [ROB_DEPTH-1:0] done;
  reg_idx_t ent_rd [ROB_DEPTH];
  word_t ent_value [ROB_DEPTH];
  rob_tag_t head;
  rob_tag_t tail;
  logic [ROB_TAG_W:0] count;

  assign o_alloc_tag = tail;
  assign o_full = (count == ROB_DEPTH);

  always_comb begin
    for (int k = 0; k < 2; k++) begin
      o_lookup_done[k] = done[i_lookup_tag[k]];
      o_lookup_value[k] = ent_value[i_lookup_tag[k]];
    end
  end

  // head retires in the cycle after its CDB write
  assign o_commit_valid = live[head] && done[head];
  assign o_commit_rd = ent_rd[head];
  assign o_commit_tag = head;
  assign o_commit_value = ent_value[head];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      live <= '0;
      done <= '0;
      head <= '0;
      tail <= '0;
      count <= '0;
    end else begin
      if (o_commit_valid) begin
        live[head] <= 1'b0;
        head <= head + 1'b1; // depth is a power of two
      end
      if (i_alloc) begin
        live[tail] <= 1'b1;
        done[tail] <= 1'b0;
        tail <= tail + 1'b1;
      end
      if (i_cdb.valid) begin
        done[i_cdb.tag] <= 1'b1;
      end
      case ({i_alloc, o_commit_valid})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_alloc) begin
      ent_rd[tail] <= i_alloc_rd;
    end
    if (i_cdb.valid) begin
      ent_value[i_cdb.tag] <= i_cdb.value;
    end
  end

  // issue must hold off while the ring is full
  a_alloc_not_full: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    i_alloc |-> !o_full);

  // live bits and the occupancy count must agree
  a_commit_not_empty: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    o_commit_valid |-> count != '0);

  // a broadcast tag always belongs to an op still in flight
  a_cdb_live_entry: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    i_cdb.valid |-> live[i_cdb.tag]);

endmodule

// File: logic/reservation_station.sv
`timescale 1ns/1ps

module reservation_station #(
  parameter int RS_DEPTH = 4
) (
  input  logic clk_100mhz,
  input  logic sys_rst,
  input  logic i_insert,
  input  ooo_pkg::rs_entry_t i_entry,
  input  ooo_pkg::cdb_t i_cdb,
  input  logic i_fu_busy,
  output logic [$clog2(RS_DEPTH+1)-1:0] o_free,
  output logic o_issue_valid,
  output ooo_pkg::rs_entry_t o_issue
);
  import ooo_pkg::*;

  localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

  logic [RS_DEPTH-1:0] busy;
  rs_entry_t slot [RS_DEPTH];
  logic [IDX_W-1:0] age [RS_DEPTH]; // count of younger slots
  logic [IDX_W-1:0] ins_idx;
  logic [IDX_W-1:0] sel_idx;
  logic found;
  rs_entry_t ins_entry;

  function automatic operand_t snoop(operand_t opnd, cdb_t cdb);
    operand_t res;
    res = opnd;
    if (!opnd.ready && cdb.valid && cdb.tag == opnd.tag) begin
      res.ready = 1'b1;
      res.value = cdb.value;
    end
    return res;
  endfunction

  always_comb begin
    ins_entry = i_entry;
    ins_entry.src1 = snoop(i_entry.src1, i_cdb); // same-cycle broadcast
    ins_entry.src2 = snoop(i_entry.src2, i_cdb);
  end

  // lowest free slot for insert, oldest ready slot for dispatch
  always_comb begin
    found = 1'b0;
    sel_idx = '0;
    ins_idx = '0;
    o_free = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        ins_idx = IDX_W'(i);
        o_free = o_free + 1'b1;
      end
      if (busy[i] && slot[i].src1.ready && slot[i].src2.ready &&
          (!found || age[i] > age[sel_idx])) begin
        found = 1'b1;
        sel_idx = IDX_W'(i);
      end
    end
  end

  assign o_issue_valid = found && !i_fu_busy;
  assign o_issue = slot[sel_idx];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      busy <= '0;
    end else begin
      if (o_issue_valid) begin
        busy[sel_idx] <= 1'b0;
      end
      if (i_insert) begin
        busy[ins_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      slot[i].src1 <= snoop(slot[i].src1, i_cdb);
      slot[i].src2 <= snoop(slot[i].src2, i_cdb);
      if (busy[i]) begin
        // older slots move up a rank when a younger one leaves
        age[i] <= age[i] + IDX_W'(i_insert)
                  - IDX_W'(o_issue_valid && age[i] > age[sel_idx]);
      end
    end
    if (i_insert) begin
      slot[ins_idx] <= ins_entry;
      age[ins_idx] <= '0;
    end
  end

  // issue unit checks the free count before inserting
  a_insert_not_full: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    i_insert |-> o_free != '0);

endmodule

// File: ooo_core.f
+incdir+sim
logic/ooo_pkg.sv
logic/issue_unit.sv
logic/register_status.sv
logic/reorder_buffer.sv
logic/reservation_station.sv
logic/alu_unit.sv
logic/mul_unit.sv
logic/cdb_arbiter.sv
logic/ooo_core.sv
sim/tb_ooo_core.sv

// File: sim/tb_ooo_model.svh
`ifndef TB_OOO_MODEL_SVH
`define TB_OOO_MODEL_SVH

word_t model_regs [NUM_REGS]; // in-order reference state, x0 stays zero
logic [31:0] rng_state;
int burst_end;

// stimulus rows, read by the driver
uop_t stim_ops [$];
string stim_names [$];
int stim_gaps [$];

// expected commits, popped by the monitor
reg_idx_t exp_rd [$];
word_t exp_value [$];
string exp_names [$];

function automatic logic [31:0] xorshift(logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

function automatic word_t expected_result(alu_op_e op, word_t a, word_t b);
  word_t y;
  case (op)
    ADD:  y = a + b;
    SUB:  y = a - b;
    AND:  y = a & b;
    OR:   y = a | b;
    XOR:  y = a ^ b;
    SLL:  y = a << b[4:0]; // shift amount from low 5 bits
    SRL:  y = a >> b[4:0];
    SRA:  y = word_t'($signed(a) >>> b[4:0]);
    SLT:  y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    SLTU: y = (a < b) ? 32'd1 : 32'd0;
    MUL:  y = a * b; // low word of the product
    default: y = '0;
  endcase
  return y;
endfunction

// runs the op on the model and records both the row and its commit
task automatic queue_op(string name, alu_op_e op, reg_idx_t rd, reg_idx_t rs1,
                        reg_idx_t rs2, logic use_imm, logic [27:0] imm, int gap);
  uop_t u;
  word_t a;
  word_t b;
  word_t y;
  u.op = op;
  u.rd = rd;
  u.rs1 = rs1;
  u.rs2 = rs2;
  u.use_imm = use_imm;
  u.imm = imm;
  a = model_regs[rs1];
  b = use_imm ? {{4{imm[27]}}, imm} : model_regs[rs2];
  y = expected_result(op, a, b);
  if (rd != '0) begin
    model_regs[rd] = y;
  end
  exp_names.push_back($sformatf("%s #%0d", name, stim_ops.size()));
  exp_rd.push_back(rd);
  exp_value.push_back(y);
  stim_ops.push_back(u);
  stim_names.push_back(name);
  stim_gaps.push_back(gap);
endtask

task automatic queue_rr(string name, alu_op_e op, reg_idx_t rd, reg_idx_t rs1,
                        reg_idx_t rs2);
  queue_op(name, op, rd, rs1, rs2, 1'b0, '0, 0);
endtask

task automatic queue_ri(string name, alu_op_e op, reg_idx_t rd, reg_idx_t rs1,
                        logic [27:0] imm);
  queue_op(name, op, rd, rs1, '0, 1'b1, imm, 0);
endtask

task automatic build_alu_ops();
  alu_op_e op;
  queue_ri("alu_seed", ADD, 5'd1, 5'd0, 28'd1234);
  queue_ri("alu_seed", ADD, 5'd2, 5'd0, 28'hFFFFFB3); // -77
  for (int k = 0; k <= 9; k++) begin
    op = alu_op_e'(k);
    queue_rr("alu_rr", op, reg_idx_t'(4 + k), 5'd1, 5'd2);
    queue_ri("alu_ri", op, reg_idx_t'(14 + k), 5'd2, 28'(k[0] ? -(k + 2) : k + 3));
  end
endtask

task automatic build_raw_chain();
  queue_rr("raw_chain", MUL, 5'd1, 5'd1, 5'd2);
  queue_rr("raw_chain", ADD, 5'd5, 5'd1, 5'd1); // reads the product
  queue_rr("raw_chain", MUL, 5'd6, 5'd5, 5'd2);
  queue_rr("raw_chain", SUB, 5'd7, 5'd6, 5'd1);
  queue_rr("raw_chain", XOR, 5'd8, 5'd7, 5'd6);
  queue_ri("raw_chain", SRA, 5'd9, 5'd8, 28'd3);
endtask

task automatic build_ooo_commit();
  queue_rr("ooo_commit", MUL, 5'd10, 5'd1, 5'd2);
  queue_ri("ooo_commit", ADD, 5'd11, 5'd3, 28'd1);
  queue_rr("ooo_commit", ADD, 5'd12, 5'd4, 5'd5);
  queue_ri("ooo_commit", ADD, 5'd13, 5'd12, 28'd9);
endtask

// dependent chain, so the MUL station fills and issue stalls
task automatic build_mul_burst();
  reg_idx_t prev;
  prev = 5'd1;
  for (int k = 0; k < 12; k++) begin
    queue_rr("mul_burst", MUL, reg_idx_t'(24 + k % 4), prev, 5'd2);
    prev = reg_idx_t'(24 + k % 4);
  end
  burst_end = stim_ops.size() - 1;
endtask

task automatic build_reg_zero();
  queue_ri("reg_zero", ADD, 5'd0, 5'd1, 28'd5);
  queue_rr("reg_zero", MUL, 5'd0, 5'd1, 5'd2);
  queue_ri("reg_zero", ADD, 5'd14, 5'd0, 28'd7);
  queue_rr("reg_zero", ADD, 5'd15, 5'd0, 5'd0);
endtask

task automatic build_random_mix(int count);
  alu_op_e op;
  logic [31:0] r;
  for (int n = 0; n < count; n++) begin
    rng_state = xorshift(rng_state);
    r = rng_state;
    op = alu_op_e'(r[3:0] % 4'd11);
    rng_state = xorshift(rng_state); // fresh word for the immediate
    queue_op("random_mix", op, reg_idx_t'(r[6:4]), reg_idx_t'(r[9:7]),
             reg_idx_t'(r[12:10]), r[13], rng_state[27:0], int'(r[15:14]));
  end
endtask

task automatic build_table();
  for (int r = 0; r < NUM_REGS; r++) begin
    model_regs[r] = '0;
  end
  rng_state = 32'd8;
  build_alu_ops();
  build_raw_chain();
  build_ooo_commit();
  build_mul_burst();
  build_reg_zero();
  build_random_mix(150);
endtask

`endif

// File: sim/tb_ooo_core.sv
`timescale 1ns/1ps

module tb_ooo_core;
  import ooo_pkg::*;

  logic clk_100mhz;
  logic sys_rst;
  logic i_op_valid;
  uop_t i_op;
  logic o_op_ready;
  logic o_commit_valid;
  reg_idx_t o_commit_rd;
  word_t o_commit_value;

  int burst_stalls; // cycles with o_op_ready low during the MUL burst
  logic table_ready;

  `include "tb_ooo_model.svh"

  ooo_core i_dut (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .i_op_valid(i_op_valid),
    .i_op(i_op),
    .o_op_ready(o_op_ready),
    .o_commit_valid(o_commit_valid),
    .o_commit_rd(o_commit_rd),
    .o_commit_value(o_commit_value)
  );

  always #5 clk_100mhz = ~clk_100mhz;

  task automatic fail_run(string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  // holds the row until the DUT accepts it, counts refused cycles
  task automatic apply_op(uop_t op, output int stalls);
    logic accepted;
    stalls = 0;
    accepted = 1'b0;
    i_op = op;
    i_op_valid = 1'b1;
    while (!accepted) begin
      @(negedge clk_100mhz);
      accepted = o_op_ready;
      if (!accepted) begin
        stalls++;
      end
      @(posedge clk_100mhz);
      #1;
    end
    i_op_valid = 1'b0;
  endtask

  task automatic check_commit();
    string name;
    reg_idx_t rd;
    word_t value;
    if (exp_value.size() == 0) begin
      fail_run("unexpected commit: o_commit_valid was high with no op left to retire");
    end else begin
      name = exp_names.pop_front();
      rd = exp_rd.pop_front();
      value = exp_value.pop_front();
      assert (o_commit_rd == rd)
        else fail_run($sformatf("FAILED %s: rd expected %0d actual %0d",
                                name, rd, o_commit_rd));
      assert (o_commit_value == value)
        else fail_run($sformatf("FAILED %s: value expected 0x%08h actual 0x%08h",
                                name, value, o_commit_value));
    end
  endtask

  // commit strobe is settled by the falling edge
  always @(negedge clk_100mhz) begin
    if (sys_rst) begin
      assert (!o_op_ready && !o_commit_valid)
        else fail_run("o_op_ready or o_commit_valid was high while reset was held");
    end else if (o_commit_valid) begin
      check_commit();
    end
  end

  initial begin
    int stalls;
    clk_100mhz = 1'b0;
    sys_rst = 1'b1;
    i_op_valid = 1'b0;
    i_op = '0;
    burst_stalls = 0;
    table_ready = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (8) @(posedge clk_100mhz);
    #1;
    sys_rst = 1'b0;
    for (int n = 0; n < stim_ops.size(); n++) begin
      apply_op(stim_ops[n], stalls);
      if (n == 0) begin
        assert (stalls == 0)
          else fail_run("o_op_ready was not high in the first cycle after reset");
      end
      if (stim_names[n] == "mul_burst") begin
        burst_stalls += stalls;
      end
      if (n == burst_end) begin
        assert (burst_stalls > 0)
          else fail_run("o_op_ready never dropped during the back-to-back MUL burst");
      end
      repeat (stim_gaps[n]) begin
        @(posedge clk_100mhz);
        #1;
      end
    end
    while (exp_value.size() != 0) begin
      @(posedge clk_100mhz);
    end
    repeat (20) @(posedge clk_100mhz); // room for a stray extra commit
    $display("NO ERRORS");
    $finish;
  end

  // run limit scales with the table length
  initial begin
    int limit;
    wait (table_ready);
    limit = 40 * stim_ops.size() + 200;
    repeat (8 + limit) @(posedge clk_100mhz);
    fail_run($sformatf("timeout: run did not finish within %0d cycles, %0d commits missing",
                       limit, exp_value.size()));
  end

endmodule
